//--- Bender.yml
package:
  name: spi_master

sources:
  - rtl/spiPkg.sv
  - rtl/spiRegCtrl.sv
  - rtl/spiClockGen.sv
  - rtl/spiShifter.sv
  - rtl/spiMaster.sv
  - target: simulation
    files:
      - sim/spiMasterTb.sv

//--- filelist.f
rtl/spiPkg.sv
rtl/spiRegCtrl.sv
rtl/spiClockGen.sv
rtl/spiShifter.sv
rtl/spiMaster.sv
sim/spiMasterTb.sv

//--- rtl/spiClockGen.sv
`timescale 1ns/1ps

module spiClockGen (
   input  logic       cp2,
   input  logic       ireset,
   input  logic       busy,
   input  logic       start,
   input  logic       ctrlWrite,
   input  logic       cpolNew,
   input  logic       cpol,
   input  logic       cpha,
   input  logic [1:0] spr,
   input  logic       spi2x,
   output logic       scko,
   output logic       bitStep,
   output logic       samplePulse
);

   logic [spiPkg::DivWidth-1:0] divCnt;
   logic [spiPkg::DivWidth-1:0] divTerm;   // Half period minus one
   logic                        halfTick;
   logic                        phase;     // Second half of the bit when set
   logic                        sckReg;
   logic                        sckNext;
   logic                        sampleEdge;

   // ********************************************************
   // Rate divider
   // ********************************************************

   always_comb
   begin
      case ({spi2x, spr})
         3'b000:  divTerm = spiPkg::DivWidth'(1);    // fosc/4
         3'b001:  divTerm = spiPkg::DivWidth'(7);    // fosc/16
         3'b010:  divTerm = spiPkg::DivWidth'(31);   // fosc/64
         3'b011:  divTerm = spiPkg::DivWidth'(63);   // fosc/128
         3'b100:  divTerm = spiPkg::DivWidth'(0);    // fosc/2
         3'b101:  divTerm = spiPkg::DivWidth'(3);    // fosc/8
         3'b110:  divTerm = spiPkg::DivWidth'(15);   // fosc/32
         default: divTerm = spiPkg::DivWidth'(31);   // fosc/64
      endcase
   end

   assign halfTick = busy & (divCnt == divTerm);
   assign bitStep  = halfTick & phase;   // End of a full bit period

   always_ff @(posedge cp2)
   begin
      if (!ireset)
      begin
         divCnt <= '0;
         phase  <= 1'b0;
      end
      else if (!busy)
      begin
         divCnt <= '0;   // Each transfer starts from a clean count
         phase  <= 1'b0;
      end
      else if (halfTick)
      begin
         divCnt <= '0;
         phase  <= ~phase;
      end
      else
         divCnt <= divCnt + 1'b1;
   end

   // ********************************************************
   // SCK waveform
   // ********************************************************

   always_comb
   begin
      sckNext = sckReg;
      if (ctrlWrite)
         sckNext = cpolNew;
      else if (start)
         sckNext = cpha ? ~cpol : cpol;   // CPHA leading edge on start
      else if (halfTick)
         sckNext = ~sckReg;
   end

   // Rising edge when CPOL equals CPHA, falling otherwise
   assign sampleEdge = (cpol == cpha) ? (~sckReg & sckNext) : (sckReg & ~sckNext);

   always_ff @(posedge cp2)
   begin
      if (!ireset)
      begin
         sckReg      <= 1'b0;
         samplePulse <= 1'b0;
      end
      else
      begin
         sckReg      <= sckNext;
         samplePulse <= busy & sampleEdge;
      end
   end

   // Parked at CPOL between transfers, so the last CPHA edge never shows
   assign scko = busy ? sckReg : cpol;

endmodule

//--- rtl/spiMaster.sv
`timescale 1ns/1ps

module spiMaster #(
   parameter logic [spiPkg::AddrWidth-1:0] SpcrAddr = 6'h0D,
   parameter logic [spiPkg::AddrWidth-1:0] SpsrAddr = 6'h0E,
   parameter logic [spiPkg::AddrWidth-1:0] SpdrAddr = 6'h0F
) (
   input  logic                           cp2,
   input  logic                           ireset,
   input  logic [spiPkg::AddrWidth-1:0]   adr,
   input  logic [spiPkg::DataWidth-1:0]   dbusIn,
   input  logic                           iore,
   input  logic                           iowe,
   output logic [spiPkg::DataWidth-1:0]   dbusOut,
   output logic                           outEn,
   input  logic                           misoi,
   output logic                           mosio,
   output logic                           scko,
   output logic                           spe,
   output logic                           spimaster,
   output logic                           spiirq,
   input  logic                           spiack
);

   logic                         start;
   logic                         done;
   logic                         busy;
   logic                         ctrlWrite;
   logic                         cpolNew;
   logic                         cpol;
   logic                         cpha;
   logic                         dord;
   logic [1:0]                   spr;
   logic                         spi2x;
   logic                         bitStep;
   logic                         samplePulse;
   logic [spiPkg::DataWidth-1:0] rxData;

   spiRegCtrl #(
      .SpcrAddr (SpcrAddr),
      .SpsrAddr (SpsrAddr),
      .SpdrAddr (SpdrAddr)
   ) spiRegCtrl_inst (
      .cp2       (cp2),       .ireset    (ireset),
      .adr       (adr),       .dbusIn    (dbusIn),
      .iore      (iore),      .iowe      (iowe),
      .spiack    (spiack),    .dbusOut   (dbusOut),
      .outEn     (outEn),     .bitStep   (bitStep),
      .rxData    (rxData),    .start     (start),
      .done      (done),      .busy      (busy),
      .ctrlWrite (ctrlWrite), .cpolNew   (cpolNew),
      .cpol      (cpol),      .cpha      (cpha),
      .dord      (dord),      .spr       (spr),
      .spi2x     (spi2x),     .spe       (spe),
      .spimaster (spimaster), .spiirq    (spiirq)
   );

   spiClockGen spiClockGen_inst (
      .cp2         (cp2),       .ireset    (ireset),
      .busy        (busy),      .start     (start),
      .ctrlWrite   (ctrlWrite), .cpolNew   (cpolNew),
      .cpol        (cpol),      .cpha      (cpha),
      .spr         (spr),       .spi2x     (spi2x),
      .scko        (scko),      .bitStep   (bitStep),
      .samplePulse (samplePulse)
   );

   // Loads on the same edge the sequencer leaves idle
   spiShifter spiShifter_inst (
      .cp2         (cp2),         .ireset  (ireset),
      .start       (start),       .txData  (dbusIn),
      .dord        (dord),        .bitStep (bitStep),
      .samplePulse (samplePulse), .done    (done),
      .misoi       (misoi),       .mosio   (mosio),
      .rxData      (rxData)
   );

endmodule

//--- rtl/spiPkg.sv
package spiPkg;

   // ********************************************************
   // Bus and counter widths
   // ********************************************************

   localparam int AddrWidth   = 6;   // I/O address space
   localparam int DataWidth   = 8;   // Data bus and shift register
   localparam int DivWidth    = 6;   // Rate divider
   localparam int BitCntWidth = 4;   // Transfer state / bit counter

   // ********************************************************
   // SPCR bit positions
   // ********************************************************

   localparam int SpieBit = 7;   // Interrupt enable
   localparam int SpeBit  = 6;   // SPI enable
   localparam int DordBit = 5;   // LSB first when set
   localparam int MstrBit = 4;
   localparam int CpolBit = 3;
   localparam int CphaBit = 2;
   localparam int SprMsb  = 1;
   localparam int SprLsb  = 0;

   // SPSR bit positions
   localparam int SpifBit  = 7;   // Transfer complete
   localparam int WcolBit  = 6;   // Write collision
   localparam int Spi2xBit = 0;   // Double speed

   // Master transfer sequence, one state per bit
   typedef enum logic [BitCntWidth-1:0] {
      XferIdle = 4'd0,
      XferBit0 = 4'd1,
      XferBit1 = 4'd2,
      XferBit2 = 4'd3,
      XferBit3 = 4'd4,
      XferBit4 = 4'd5,
      XferBit5 = 4'd6,
      XferBit6 = 4'd7,
      XferBit7 = 4'd8
   } xferStateT;

endpackage

//--- rtl/spiRegCtrl.sv
`timescale 1ns/1ps

module spiRegCtrl #(
   parameter logic [spiPkg::AddrWidth-1:0] SpcrAddr = 6'h0D,
   parameter logic [spiPkg::AddrWidth-1:0] SpsrAddr = 6'h0E,
   parameter logic [spiPkg::AddrWidth-1:0] SpdrAddr = 6'h0F
) (
   input  logic                           cp2,
   input  logic                           ireset,
   input  logic [spiPkg::AddrWidth-1:0]   adr,
   input  logic [spiPkg::DataWidth-1:0]   dbusIn,
   input  logic                           iore,
   input  logic                           iowe,
   input  logic                           spiack,
   output logic [spiPkg::DataWidth-1:0]   dbusOut,
   output logic                           outEn,
   input  logic                           bitStep,
   input  logic [spiPkg::DataWidth-1:0]   rxData,
   output logic                           start,
   output logic                           done,
   output logic                           busy,
   output logic                           ctrlWrite,
   output logic                           cpolNew,
   output logic                           cpol,
   output logic                           cpha,
   output logic                           dord,
   output logic [1:0]                     spr,
   output logic                           spi2x,
   output logic                           spe,
   output logic                           spimaster,
   output logic                           spiirq
);

   logic [spiPkg::DataWidth-1:0] spcr;
   logic                         spif;
   logic                         wcol;
   logic                         spifArm;   // Status read seen with SPIF set
   logic                         wcolArm;   // Status read seen with WCOL set

   spiPkg::xferStateT            xferState;
   spiPkg::xferStateT            xferNext;

   logic                         spcrSel;
   logic                         spsrSel;
   logic                         spdrSel;
   logic                         statusWrite;
   logic                         statusRead;
   logic                         dataWrite;
   logic                         dataAccess;
   logic                         collision;
   logic                         lastStep;

   // ********************************************************
   // Bus decode
   // ********************************************************

   assign spcrSel     = (adr == SpcrAddr);
   assign spsrSel     = (adr == SpsrAddr);
   assign spdrSel     = (adr == SpdrAddr);

   assign ctrlWrite   = spcrSel & iowe;
   assign statusWrite = spsrSel & iowe;
   assign statusRead  = spsrSel & iore;
   assign dataWrite   = spdrSel & iowe;
   assign dataAccess  = spdrSel & (iore | iowe);

   assign cpolNew     = dbusIn[spiPkg::CpolBit];

   // SPCR fields
   assign spe       = spcr[spiPkg::SpeBit];
   assign spimaster = spcr[spiPkg::MstrBit];
   assign dord      = spcr[spiPkg::DordBit];
   assign cpol      = spcr[spiPkg::CpolBit];
   assign cpha      = spcr[spiPkg::CphaBit];
   assign spr       = spcr[spiPkg::SprMsb:spiPkg::SprLsb];

   assign busy      = (xferState != spiPkg::XferIdle);
   assign start     = dataWrite & spe & spimaster & ~busy;
   assign collision = dataWrite & busy;   // Refused write
   assign lastStep  = (xferState == spiPkg::XferBit7) & bitStep;

   assign spiirq    = spcr[spiPkg::SpieBit] & spif;

   always_ff @(posedge cp2)
   begin
      if (!ireset)
      begin
         spcr  <= '0;
         spi2x <= 1'b0;
      end
      else
      begin
         if (ctrlWrite)
            spcr <= dbusIn;
         if (statusWrite)
            spi2x <= dbusIn[spiPkg::Spi2xBit];   // Only writable SPSR bit
      end
   end

   // ********************************************************
   // Transfer sequencer
   // ********************************************************

   always_comb
   begin
      xferNext = xferState;
      if (!busy)
      begin
         if (start)
            xferNext = spiPkg::XferBit0;
      end
      else if (bitStep)
      begin
         if (xferState == spiPkg::XferBit7)
            xferNext = spiPkg::XferIdle;
         else
            xferNext = spiPkg::xferStateT'(xferState + 1'b1);
      end
   end

   always_ff @(posedge cp2)
   begin
      if (!ireset)
      begin
         xferState <= spiPkg::XferIdle;
         done      <= 1'b0;
      end
      else
      begin
         xferState <= xferNext;
         done      <= lastStep;   // Receive register update strobe
      end
   end

   // ********************************************************
   // SPIF / WCOL flags and their clear sequences
   // ********************************************************

   always_ff @(posedge cp2)
   begin
      if (!ireset)
      begin
         spif    <= 1'b0;
         wcol    <= 1'b0;
         spifArm <= 1'b0;
         wcolArm <= 1'b0;
      end
      else
      begin
         if (statusRead && spif)
            spifArm <= 1'b1;
         else if (dataAccess)
            spifArm <= 1'b0;

         if (statusRead && wcol)
            wcolArm <= 1'b1;
         else if (dataAccess)
            wcolArm <= 1'b0;

         if (lastStep)
            spif <= 1'b1;
         else if (spiack || (spifArm && dataAccess))
            spif <= 1'b0;

         // A colliding write never clears its own flag
         if (collision)
            wcol <= 1'b1;
         else if (wcolArm && dataAccess)
            wcol <= 1'b0;
      end
   end

   // Read mux
   always_comb
   begin
      dbusOut = '0;
      outEn   = 1'b0;
      if (spdrSel)
      begin
         dbusOut = rxData;
         outEn   = iore;
      end
      else if (spsrSel)
      begin
         dbusOut[spiPkg::SpifBit]  = spif;
         dbusOut[spiPkg::WcolBit]  = wcol;
         dbusOut[spiPkg::Spi2xBit] = spi2x;
         outEn                     = iore;
      end
      else if (spcrSel)
      begin
         dbusOut = spcr;
         outEn   = iore;
      end
   end

endmodule

//--- rtl/spiShifter.sv
`timescale 1ns/1ps

module spiShifter (
   input  logic                           cp2,
   input  logic                           ireset,
   input  logic                           start,
   input  logic [spiPkg::DataWidth-1:0]   txData,
   input  logic                           dord,
   input  logic                           bitStep,
   input  logic                           samplePulse,
   input  logic                           done,
   input  logic                           misoi,
   output logic                           mosio,
   output logic [spiPkg::DataWidth-1:0]   rxData
);

   logic [spiPkg::DataWidth-1:0] shReg;
   logic [spiPkg::DataWidth-1:0] shNext;
   logic                         holdBit;   // Last sampled MISO
   logic                         inBit;

   function automatic logic [spiPkg::DataWidth-1:0] reverseBits(
      input logic [spiPkg::DataWidth-1:0] value
   );
      logic [spiPkg::DataWidth-1:0] res;
      for (int i = 0; i < spiPkg::DataWidth; i++)
         res[i] = value[spiPkg::DataWidth-1-i];
      return res;
   endfunction

   // At fosc/2 the sample and the shift fall in the same cycle
   assign inBit = samplePulse ? misoi : holdBit;

   // ********************************************************
   // Load / shift
   // ********************************************************

   always_comb
   begin
      shNext = shReg;
      if (start)
      begin
         if (dord)
            shNext = reverseBits(txData);   // LSB goes out first
         else
            shNext = txData;
      end
      else if (done)
         shNext[spiPkg::DataWidth-1] = 1'b1;
      else if (bitStep)
         shNext = {shReg[spiPkg::DataWidth-2:0], inBit};
   end

   always_ff @(posedge cp2)
   begin
      if (!ireset)
      begin
         shReg   <= '1;
         mosio   <= 1'b0;
         holdBit <= 1'b0;
         rxData  <= '0;
      end
      else
      begin
         shReg <= shNext;
         mosio <= shNext[spiPkg::DataWidth-1];   // Tracks the MSB
         if (samplePulse)
            holdBit <= misoi;
         if (done)
            rxData <= dord ? reverseBits(shReg) : shReg;
      end
   end

endmodule

//--- sim/spiMasterTb.sv
`timescale 1ns/1ps

module spiMasterTb;

   localparam logic [spiPkg::AddrWidth-1:0] SpcrAddr = 6'h0D;
   localparam logic [spiPkg::AddrWidth-1:0] SpsrAddr = 6'h0E;
   localparam logic [spiPkg::AddrWidth-1:0] SpdrAddr = 6'h0F;
   localparam int SpifTimeout = 4096;      // Slowest transfer takes 1024 cycles
   localparam int IdleWait    = 256 * 8;

   logic                         cp2;
   logic                         ireset;
   logic [spiPkg::AddrWidth-1:0] adr;
   logic [spiPkg::DataWidth-1:0] dbusIn;
   logic                         iore;
   logic                         iowe;
   logic [spiPkg::DataWidth-1:0] dbusOut;
   logic                         outEn;
   logic                         misoi;
   logic                         mosio;
   logic                         scko;
   logic                         spe;
   logic                         spimaster;
   logic                         spiirq;
   logic                         spiack;

   int         errCount    = 0;
   int         checkCount  = 0;
   int         testCount   = 0;
   int         failedTests = 0;
   int         testErrBase = 0;
   string      testName;
   int         edgeCount   = 0;   // Sampling edges in the current transfer
   int         sckChanges  = 0;
   logic       curCpol     = 1'b0;
   logic       curCpha     = 1'b0;
   logic       xferActive  = 1'b0;
   logic       prevSck     = 1'b0;
   logic [7:0] expSerial;         // Bit 7 goes out first
   logic [7:0] expRx;
   logic [7:0] txByte;
   logic [7:0] rd;
   logic       en;

   spiMaster #(
      .SpcrAddr (SpcrAddr),
      .SpsrAddr (SpsrAddr),
      .SpdrAddr (SpdrAddr)
   ) spiMaster_inst (
      .cp2     (cp2),     .ireset    (ireset),
      .adr     (adr),     .dbusIn    (dbusIn),
      .iore    (iore),    .iowe      (iowe),
      .dbusOut (dbusOut), .outEn     (outEn),
      .misoi   (misoi),   .mosio     (mosio),
      .scko    (scko),    .spe       (spe),
      .spimaster (spimaster),
      .spiirq  (spiirq),  .spiack    (spiack)
   );

   assign misoi = mosio;   // Loopback

   initial
   begin
      cp2 = 1'b0;
      forever #4 cp2 = ~cp2;
   end

   // ********************************************************
   // Reference model and checking
   // ********************************************************

   // Wire order in bits 15:8 and the reassembled byte in 7:0
   function automatic logic [15:0] refTransfer(input logic [7:0] value, input logic lsbFirst);
      logic [7:0] order;
      logic [7:0] rx;
      for (int i = 0; i < 8; i++)
         order[7-i] = lsbFirst ? value[i] : value[7-i];
      for (int i = 0; i < 8; i++)
      begin
         if (lsbFirst)
            rx[i] = order[7-i];
         else
            rx[7-i] = order[7-i];
      end
      return {order, rx};
   endfunction

   function automatic logic [7:0] spcrValue(input logic spie, input logic speOn,
                                            input logic lsbFirst, input logic mstr,
                                            input logic pol, input logic pha,
                                            input logic [1:0] rate);
      logic [7:0] v;
      v = '0;
      v[spiPkg::SpieBit] = spie;
      v[spiPkg::SpeBit]  = speOn;
      v[spiPkg::DordBit] = lsbFirst;
      v[spiPkg::MstrBit] = mstr;
      v[spiPkg::CpolBit] = pol;
      v[spiPkg::CphaBit] = pha;
      v[spiPkg::SprMsb:spiPkg::SprLsb] = rate;
      return v;
   endfunction

   task automatic checkValue(input string name, input logic [7:0] got, input logic [7:0] exp);
      checkCount++;
      assert (got === exp)
      else
      begin
         $display("error at %0t: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
         errCount++;
      end
   endtask

   // Checks mosio at each sampling edge of SCK
   always @(negedge cp2)
   begin
      if (ireset && scko !== prevSck)
      begin
         sckChanges++;
         if (xferActive && scko == (curCpol == curCpha))
         begin
            if (edgeCount < 8)
               checkValue("mosio", {7'b0, mosio}, {7'b0, expSerial[7-edgeCount]});
            edgeCount++;
         end
      end
      prevSck = scko;
   end

   // ********************************************************
   // Bus tasks
   // ********************************************************

   task automatic busWrite(input logic [5:0] a, input logic [7:0] d);
      @(posedge cp2);
      adr    <= a;
      dbusIn <= d;
      iowe   <= 1'b1;
      @(posedge cp2);
      iowe   <= 1'b0;
   endtask

   task automatic busRead(input logic [5:0] a, output logic [7:0] d, output logic oe);
      @(posedge cp2);
      adr  <= a;
      iore <= 1'b1;
      @(negedge cp2);
      d  = dbusOut;
      oe = outEn;
      @(posedge cp2);
      iore <= 1'b0;
   endtask

   // Polls SPSR the way AVR firmware does
   task automatic waitSpif();
      logic [7:0] status;
      logic       oe;
      logic       found;
      int         cycles;
      found  = 1'b0;
      cycles = 0;
      while (!found && cycles < SpifTimeout)
      begin
         busRead(SpsrAddr, status, oe);
         found  = status[spiPkg::SpifBit];
         cycles += 2;
      end
      if (!found)
      begin
         $display("timeout: SPIF did not set within %0d cycles", SpifTimeout);
         errCount++;
      end
   endtask

   task automatic waitIrq();
      logic found;
      int   cycles;
      found  = 1'b0;
      cycles = 0;
      while (!found && cycles < SpifTimeout)
      begin
         @(negedge cp2);
         found = spiirq;
         cycles++;
      end
      if (!found)
      begin
         $display("timeout: spiirq did not rise within %0d cycles", SpifTimeout);
         errCount++;
      end
   endtask

   task automatic startTransfer(input logic [7:0] value, input logic spie,
                                input logic lsbFirst, input logic [1:0] mode,
                                input logic [2:0] rate);
      logic [15:0] expected;
      expected = refTransfer(value, lsbFirst);
      curCpol  = mode[1];
      curCpha  = mode[0];
      busWrite(SpcrAddr, spcrValue(spie, 1'b1, lsbFirst, 1'b1, mode[1], mode[0], rate[1:0]));
      busWrite(SpsrAddr, {7'b0, rate[2]});   // Idle level change seen meanwhile
      expSerial  = expected[15:8];
      expRx      = expected[7:0];
      edgeCount  = 0;
      xferActive = 1'b1;
      busWrite(SpdrAddr, value);
   endtask

   task automatic checkTransfer();
      logic [7:0] rx;
      logic       oe;
      xferActive = 1'b0;
      busRead(SpdrAddr, rx, oe);
      checkValue("SPDR", rx, expRx);
      checkValue("sampling edges", 8'(edgeCount), 8'd8);
      checkValue("scko", {7'b0, scko}, {7'b0, curCpol});
   endtask

   task automatic beginTest(input string name);
      testName    = name;
      testErrBase = errCount;
   endtask

   task automatic endTest();
      testCount++;
      if (errCount == testErrBase)
         $display("test %0d %s: ok", testCount, testName);
      else
      begin
         failedTests++;
         $display("test %0d %s: %0d errors", testCount, testName, errCount - testErrBase);
      end
   endtask

   // ********************************************************
   // Test sequence
   // ********************************************************

   initial
   begin
      ireset = 1'b0;
      adr    = '0;
      dbusIn = '0;
      iore   = 1'b0;
      iowe   = 1'b0;
      spiack = 1'b0;
      void'($urandom(32'h3e66));
      repeat (3) @(posedge cp2);
      ireset <= 1'b1;

      beginTest("register readback");
      busWrite(SpcrAddr, 8'hD3);
      busRead(SpcrAddr, rd, en);
      checkValue("SPCR", rd, 8'hD3);
      checkValue("spe", {7'b0, spe}, 8'd1);
      checkValue("spimaster", {7'b0, spimaster}, 8'd1);
      busWrite(SpsrAddr, 8'hFF);
      busRead(SpsrAddr, rd, en);
      checkValue("SPSR", rd, 8'h01);   // Only SPI2X is writable
      for (int a = 0; a < 64; a++)
      begin
         busRead(6'(a), rd, en);
         checkValue("outEn", {7'b0, en},
                    {7'b0, (6'(a) == SpcrAddr || 6'(a) == SpsrAddr || 6'(a) == SpdrAddr)});
      end
      busWrite(SpsrAddr, 8'h00);
      endTest();

      beginTest("loopback transfers");
      for (int m = 0; m < 4; m++)
         for (int d = 0; d < 2; d++)
            for (int r = 0; r < 8; r++)
            begin
               txByte = 8'($urandom);
               startTransfer(txByte, 1'b0, d[0], m[1:0], r[2:0]);
               waitSpif();
               checkTransfer();
            end
      endTest();

      beginTest("sck idle level");
      for (int c = 0; c < 2; c++)
      begin
         busWrite(SpcrAddr, spcrValue(1'b0, 1'b1, 1'b0, 1'b1, c[0], 1'b1, 2'd0));
         @(negedge cp2);
         checkValue("scko", {7'b0, scko}, {7'b0, c[0]});
         txByte = 8'($urandom);
         startTransfer(txByte, 1'b0, 1'b1, {c[0], 1'b1}, 3'd5);
         waitSpif();
         checkTransfer();
      end
      endTest();

      beginTest("write collision");
      txByte = 8'($urandom);
      startTransfer(txByte, 1'b0, 1'b0, 2'd0, 3'd1);
      busWrite(SpdrAddr, ~txByte);   // Lands mid-transfer
      busRead(SpsrAddr, rd, en);
      checkValue("WCOL", {7'b0, rd[spiPkg::WcolBit]}, 8'd1);
      waitSpif();
      checkTransfer();
      busRead(SpsrAddr, rd, en);
      checkValue("SPSR", rd, 8'h00);
      endTest();

      beginTest("interrupt and SPIF clearing");
      txByte = 8'($urandom);
      startTransfer(txByte, 1'b1, 1'b0, 2'd0, 3'd0);
      waitIrq();
      @(posedge cp2);
      spiack <= 1'b1;
      @(posedge cp2);
      spiack <= 1'b0;
      @(negedge cp2);
      checkValue("spiirq", {7'b0, spiirq}, 8'd0);
      busRead(SpsrAddr, rd, en);
      checkValue("SPIF", {7'b0, rd[spiPkg::SpifBit]}, 8'd0);
      checkTransfer();
      txByte = 8'($urandom);
      startTransfer(txByte, 1'b0, 1'b0, 2'd0, 3'd4);
      waitSpif();
      @(negedge cp2);
      checkValue("spiirq", {7'b0, spiirq}, 8'd0);   // SPIE still clear
      busWrite(SpcrAddr, spcrValue(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0));
      @(negedge cp2);
      checkValue("spiirq", {7'b0, spiirq}, 8'd1);
      checkTransfer();
      @(negedge cp2);
      checkValue("spiirq", {7'b0, spiirq}, 8'd0);
      busRead(SpsrAddr, rd, en);
      checkValue("SPIF", {7'b0, rd[spiPkg::SpifBit]}, 8'd0);
      endTest();

      beginTest("transfers that must not start");
      for (int k = 0; k < 2; k++)
      begin
         // SPE clear first, then MSTR clear
         busWrite(SpcrAddr, spcrValue(1'b0, k == 1, 1'b0, k == 0, 1'b0, 1'b0, 2'd0));
         @(posedge cp2);
         sckChanges = 0;
         busWrite(SpdrAddr, 8'($urandom));
         repeat (IdleWait) @(posedge cp2);
         busWrite(SpdrAddr, 8'h00);   // Would collide if busy
         busRead(SpsrAddr, rd, en);
         checkValue("SPIF", {7'b0, rd[spiPkg::SpifBit]}, 8'd0);
         checkValue("WCOL", {7'b0, rd[spiPkg::WcolBit]}, 8'd0);
         checkValue("scko changes", 8'(sckChanges), 8'd0);
      end
      endTest();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               testCount, failedTests, checkCount, errCount);
      if (errCount == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule
